/* flist.f */
hdl/dram_pkg.sv
hdl/dram_cmd_decoder.sv
hdl/dram_bank.sv
hdl/dram_read_return.sv
hdl/dram_chip_top.sv
testbench/dram_chip_tb.sv

/* hdl/dram_bank.sv */
// ##############################
// one DRAM bank with its array, row buffer and latency timer
// emits read beats one cycle ahead of the read return stage
// ##############################
`timescale 1ns/1ps

module dram_bank import dram_pkg::*; #(
    parameter int BANK_ID = 0                           // matched against wr_bank
) (
    input  logic                                  clk_in,
    input  logic                                  rst_N_in,
    input  bank_cmd_t                             bank_cmd,
    input  logic                                  sel,
    input  logic [ROW_BITS-1:0]                   cmd_row,
    input  logic [COL_BITS-1:0]                   cmd_col,
    input  logic                                  wr_done,
    input  logic [BANK_BITS-1:0]                  wr_bank,
    input  logic [BURST_LEN-1:0][DATA_WIDTH-1:0]  wr_beats,
    input  logic [BURST_LEN-1:0][DATA_WIDTH-1:0]  wr_masks,
    output logic                                  beat_valid,
    output logic [DATA_WIDTH-1:0]                 beat_data
);

    localparam int TMR_MAX  = (ACT_LATENCY > PRE_LATENCY) ? ACT_LATENCY : PRE_LATENCY;
    localparam int TMR_BITS = $clog2(TMR_MAX);
    localparam int RD_BITS  = $clog2(CAS_LATENCY);

    logic [COLS-1:0][DATA_WIDTH-1:0] mem [ROWS];        // cell array, one packed row per entry
    logic [COLS-1:0][DATA_WIDTH-1:0] row_buf;           // sense amps
    logic [ROW_BITS-1:0]             open_row;
    logic                            row_open;

    logic                            tmr_busy;          // activate or precharge in flight
    logic                            tmr_act;           // 1 activate, 0 precharge
    logic [TMR_BITS-1:0]             tmr;
    logic                            tmr_done;

    logic                            rd_pend;           // waiting out the read latency
    logic                            rd_busy;           // beats 1..3 still to go
    logic [RD_BITS-1:0]              rd_delay;
    logic [BURST_BITS-1:0]           rd_beat;
    logic [BURST_BITS-1:0]           rd_idx;
    logic                            rd_fire;
    logic [COL_BITS-1:0]             rd_col;
    logic [COL_BITS-1:0]             wr_col;
    logic                            wr_hit;

    // column of beat k, wraps inside the aligned group of BURST_LEN
    function automatic logic [COL_BITS-1:0] wrap_col(input logic [COL_BITS-1:0]   base,
                                                     input logic [BURST_BITS-1:0] k);
        logic [BURST_BITS-1:0] off;
        off = base[BURST_BITS-1:0] + k;
        return {base[COL_BITS-1:BURST_BITS], off};
    endfunction

    assign tmr_done = tmr_busy && (tmr == '0);
    assign rd_fire  = (rd_pend && rd_delay == '0) || rd_busy;
    assign rd_idx   = rd_busy ? rd_beat : '0;
    assign wr_hit   = wr_done && (wr_bank == BANK_BITS'(BANK_ID));

    // control state
    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            row_open   <= 1'b0;
            tmr_busy   <= 1'b0;
            tmr_act    <= 1'b0;
            tmr        <= '0;
            rd_pend    <= 1'b0;
            rd_busy    <= 1'b0;
            rd_delay   <= '0;
            rd_beat    <= '0;
            beat_valid <= 1'b0;
        end else begin
            if (tmr_busy) begin
                if (tmr == '0) begin
                    tmr_busy <= 1'b0;
                    row_open <= tmr_act;            // open at t+ACT, closed at t+PRE
                end else begin
                    tmr <= tmr - 1'b1;
                end
            end
            if (sel) begin
                case (bank_cmd)
                    BCMD_ACT: begin
                        tmr_busy <= 1'b1;
                        tmr_act  <= 1'b1;
                        tmr      <= TMR_BITS'(ACT_LATENCY - 2); // decoder took one cycle
                    end
                    BCMD_PRE: begin
                        tmr_busy <= 1'b1;
                        tmr_act  <= 1'b0;
                        tmr      <= TMR_BITS'(PRE_LATENCY - 2);
                    end
                    BCMD_READ: begin
                        rd_pend  <= 1'b1;
                        rd_delay <= RD_BITS'(CAS_LATENCY - 3); // decoder + return stage
                    end
                    default: ;                      // write waits for wr_done
                endcase
            end
            // read sequencer, beat 0 at t+CAS-1
            if (rd_pend) begin
                if (rd_delay == '0) begin
                    rd_pend <= 1'b0;
                    rd_busy <= 1'b1;
                    rd_beat <= BURST_BITS'(1);
                end else begin
                    rd_delay <= rd_delay - 1'b1;
                end
            end
            if (rd_busy) begin
                rd_beat <= rd_beat + 1'b1;
                if (rd_beat == BURST_BITS'(BURST_LEN - 1)) begin
                    rd_busy <= 1'b0;
                end
            end
            beat_valid <= rd_fire;
        end
    end

    // addresses latched per command
    always_ff @(posedge clk_in) begin
        if (sel && bank_cmd == BCMD_ACT)   open_row <= cmd_row;
        if (sel && bank_cmd == BCMD_READ)  rd_col   <= cmd_col;
        if (sel && bank_cmd == BCMD_WRITE) wr_col   <= cmd_col;
        if (rd_fire) beat_data <= row_buf[wrap_col(rd_col, rd_idx)];
    end

    // row buffer, loaded on open and merged with masked write beats
    always_ff @(posedge clk_in) begin
        if (tmr_done && tmr_act) begin
            row_buf <= mem[open_row];
        end else if (wr_hit) begin
            for (int k = 0; k < BURST_LEN; k++) begin
                row_buf[wrap_col(wr_col, BURST_BITS'(k))] <=
                    (row_buf[wrap_col(wr_col, BURST_BITS'(k))] & wr_masks[k]) |
                    (wr_beats[k] & ~wr_masks[k]);   // mask bit set keeps old bit
            end
        end
    end

    // write back on precharge
    always_ff @(posedge clk_in) begin
        if (tmr_done && !tmr_act) mem[open_row] <= row_buf;
    end

    a_open_access: assert property (@(posedge clk_in) disable iff (rst_N_in)
        (sel && bank_cmd inside {BCMD_READ, BCMD_WRITE, BCMD_PRE}) |-> row_open);
    a_closed_act: assert property (@(posedge clk_in) disable iff (rst_N_in)
        (sel && bank_cmd == BCMD_ACT) |-> !row_open);
    a_timer_idle: assert property (@(posedge clk_in) disable iff (rst_N_in)
        (sel && bank_cmd != BCMD_NOP) |-> !tmr_busy);

endmodule : dram_bank

/* hdl/dram_chip_top.sv */
// ##############################
// single rate x16 DDR4 style chip, decoder feeding eight banks
// read data leaves on rd_data with rd_drive as strobe
// ##############################
`timescale 1ns/1ps

module dram_chip_top import dram_pkg::*; (
    input  logic                   clk_in,
    input  logic                   rst_N_in,
    input  logic                   cs_n,
    input  logic                   act_n,
    input  logic [ADDR_BITS-1:0]   addr,         // [16:14] command, low bits row or column
    input  logic [1:0]             bg,
    input  logic [1:0]             ba,
    input  logic [DATA_WIDTH-1:0]  dq_wr,
    input  logic [DATA_WIDTH-1:0]  dm,           // set bit keeps the stored bit
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic                   rd_drive
);

    bank_cmd_t                             bank_cmd;
    logic [NUM_BANKS-1:0]                  bank_sel;
    logic [ROW_BITS-1:0]                   cmd_row;
    logic [COL_BITS-1:0]                   cmd_col;
    logic                                  wr_done;
    logic [BANK_BITS-1:0]                  wr_bank;
    logic [BURST_LEN-1:0][DATA_WIDTH-1:0]  wr_beats;
    logic [BURST_LEN-1:0][DATA_WIDTH-1:0]  wr_masks;
    logic [NUM_BANKS-1:0]                  beat_valid;
    logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]  beat_data;

    dram_cmd_decoder dec_i (
        .clk_in   (clk_in),   .rst_N_in (rst_N_in),
        .cs_n     (cs_n),     .act_n    (act_n),
        .addr     (addr),     .bg       (bg),
        .ba       (ba),       .dq_wr    (dq_wr),
        .dm       (dm),       .bank_cmd (bank_cmd),
        .bank_sel (bank_sel), .cmd_row  (cmd_row),
        .cmd_col  (cmd_col),  .wr_done  (wr_done),
        .wr_bank  (wr_bank),  .wr_beats (wr_beats),
        .wr_masks (wr_masks)
    );

    // banks see the same command, sel picks the one that acts
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        dram_bank #(.BANK_ID(b)) bank_i (
            .clk_in     (clk_in),        .rst_N_in  (rst_N_in),
            .bank_cmd   (bank_cmd),      .sel       (bank_sel[b]),
            .cmd_row    (cmd_row),       .cmd_col   (cmd_col),
            .wr_done    (wr_done),       .wr_bank   (wr_bank),
            .wr_beats   (wr_beats),      .wr_masks  (wr_masks),
            .beat_valid (beat_valid[b]), .beat_data (beat_data[b])
        );
    end

    dram_read_return ret_i (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .rd_data    (rd_data),
        .rd_drive   (rd_drive)
    );

endmodule : dram_chip_top

/* hdl/dram_cmd_decoder.sv */
// ##############################
// bus command decoder, registers one bank command per cycle
// and collects the four write beats into the burst buffer
// ##############################
`timescale 1ns/1ps

module dram_cmd_decoder import dram_pkg::*; (
    input  logic                                  clk_in,
    input  logic                                  rst_N_in,
    input  logic                                  cs_n,      // chip select, low active
    input  logic                                  act_n,     // activate, low active
    input  logic [ADDR_BITS-1:0]                  addr,
    input  logic [1:0]                            bg,
    input  logic [1:0]                            ba,
    input  logic [DATA_WIDTH-1:0]                 dq_wr,
    input  logic [DATA_WIDTH-1:0]                 dm,
    output bank_cmd_t                             bank_cmd,
    output logic [NUM_BANKS-1:0]                  bank_sel,
    output logic [ROW_BITS-1:0]                   cmd_row,
    output logic [COL_BITS-1:0]                   cmd_col,
    output logic                                  wr_done,
    output logic [BANK_BITS-1:0]                  wr_bank,
    output logic [BURST_LEN-1:0][DATA_WIDTH-1:0]  wr_beats,
    output logic [BURST_LEN-1:0][DATA_WIDTH-1:0]  wr_masks
);

    logic [BANK_BITS-1:0]                 bank_idx;
    logic [2:0]                           cmd_pat;
    bank_cmd_t                            next_cmd;
    logic                                 wr_start;
    logic                                 collecting;   // write burst in progress
    logic [BURST_BITS:0]                  beat_cnt;     // next beat slot, BURST_LEN when full
    logic [BANK_BITS-1:0]                 coll_bank;
    logic [BURST_LEN-1:0][DATA_WIDTH-1:0] beat_buf;
    logic [BURST_LEN-1:0][DATA_WIDTH-1:0] mask_buf;

    assign bank_idx = {bg[0], ba};                      // bg[1] unused on an x16 part
    assign cmd_pat  = addr[ADDR_BITS-1 -: 3];           // ras_n, cas_n, we_n

    always_comb begin
        next_cmd = BCMD_NOP;
        if (!cs_n) begin
            if (!act_n) begin
                next_cmd = BCMD_ACT;                    // act_n wins over the pattern
            end else begin
                case (cmd_pat)
                    CMD_READ:  next_cmd = BCMD_READ;
                    CMD_WRITE: next_cmd = BCMD_WRITE;   // a10 ignored, no auto precharge
                    CMD_PRE:   next_cmd = BCMD_PRE;
                    default:   next_cmd = BCMD_NOP;     // refresh, mrs etc are dropped
                endcase
            end
        end
    end

    assign wr_start = (next_cmd == BCMD_WRITE) && !collecting;

    // command stage
    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            bank_cmd <= BCMD_NOP;
            bank_sel <= '0;
        end else begin
            bank_cmd <= next_cmd;
            bank_sel <= (next_cmd == BCMD_NOP) ? '0 : (NUM_BANKS'(1) << bank_idx);
        end
    end

    always_ff @(posedge clk_in) begin
        cmd_row <= addr[ROW_BITS-1:0];                  // row on activate
        cmd_col <= addr[COL_BITS-1:0];                  // column on read or write
    end

    // write burst counter, beat 0 comes with the command itself
    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            collecting <= 1'b0;
            beat_cnt   <= '0;
            wr_done    <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (wr_start) begin
                collecting <= 1'b1;
                beat_cnt   <= (BURST_BITS+1)'(1);
            end else if (collecting) begin
                if (beat_cnt == (BURST_BITS+1)'(BURST_LEN)) begin
                    collecting <= 1'b0;
                    wr_done    <= 1'b1;             // one cycle after the last beat
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // burst buffer, handed to the banks only when complete
    always_ff @(posedge clk_in) begin
        if (wr_start) begin
            beat_buf[0] <= dq_wr;
            mask_buf[0] <= dm;
            coll_bank   <= bank_idx;
        end else if (collecting && beat_cnt != (BURST_BITS+1)'(BURST_LEN)) begin
            beat_buf[beat_cnt[BURST_BITS-1:0]] <= dq_wr;
            mask_buf[beat_cnt[BURST_BITS-1:0]] <= dm;
        end
        if (collecting && beat_cnt == (BURST_BITS+1)'(BURST_LEN)) begin
            wr_beats <= beat_buf;                       // held until the next burst ends
            wr_masks <= mask_buf;
            wr_bank  <= coll_bank;
        end
    end

    // a write may only start once the previous burst has been collected
    a_no_write_overlap: assert property (@(posedge clk_in) disable iff (rst_N_in)
        (next_cmd == BCMD_WRITE) |-> !collecting);

endmodule : dram_cmd_decoder

/* hdl/dram_pkg.sv */
// ##############################
// geometry, latencies and command codes shared by the DRAM chip model
// pulled into each module header with a wildcard import
// ##############################
package dram_pkg;

    // geometry of one x16 chip
    localparam int DATA_WIDTH = 16;             // bits per beat
    localparam int ROW_BITS   = 4;              // 16 rows per bank
    localparam int COL_BITS   = 4;              // 16 columns per row
    localparam int BANK_BITS  = 3;              // {bg[0], ba[1:0]}
    localparam int NUM_BANKS  = 8;
    localparam int ROWS       = 1 << ROW_BITS;
    localparam int COLS       = 1 << COL_BITS;
    localparam int ADDR_BITS  = 17;             // full DDR4 address bus

    // fixed burst of four, wrapping inside an aligned column group
    localparam int BURST_LEN  = 4;
    localparam int BURST_BITS = 2;

    // latencies in clock cycles, counted from the bus command edge
    localparam int ACT_LATENCY = 4;             // activate to open row
    localparam int CAS_LATENCY = 6;             // read to first beat on rd_data
    localparam int PRE_LATENCY = 3;             // precharge to closed bank

    // {ras_n, cas_n, we_n} on addr[16:14] while act_n is high
    localparam logic [2:0] CMD_READ  = 3'b101;
    localparam logic [2:0] CMD_WRITE = 3'b100;
    localparam logic [2:0] CMD_PRE   = 3'b010;
    // activate is act_n low, the address then carries the row

    // per-bank command after decode
    typedef enum logic [2:0] {
        BCMD_NOP   = 3'd0,
        BCMD_ACT   = 3'd1,
        BCMD_READ  = 3'd2,
        BCMD_WRITE = 3'd3,
        BCMD_PRE   = 3'd4
    } bank_cmd_t;

endpackage : dram_pkg

/* hdl/dram_read_return.sv */
// ##############################
// merges bank read beats onto the chip read port
// last register stage of the CAS latency
// ##############################
`timescale 1ns/1ps

module dram_read_return import dram_pkg::*; (
    input  logic                                  clk_in,
    input  logic                                  rst_N_in,
    input  logic [NUM_BANKS-1:0]                  beat_valid,
    input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]  beat_data,
    output logic [DATA_WIDTH-1:0]                 rd_data,
    output logic                                  rd_drive     // strobe, replaces the dq output enable
);

    logic [DATA_WIDTH-1:0] mux_data;

    // at most one bank talks at a time, so an and-or mux is enough
    always_comb begin
        mux_data = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (beat_valid[i]) mux_data = mux_data | beat_data[i];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            rd_drive <= 1'b0;
        end else begin
            rd_drive <= |beat_valid;                // high at t+CAS..t+CAS+3
        end
    end

    always_ff @(posedge clk_in) begin
        rd_data <= mux_data;
    end

    // reads spaced BURST_LEN apart never collide on the shared port
    a_one_talker: assert property (@(posedge clk_in) disable iff (rst_N_in)
        $onehot0(beat_valid));

endmodule : dram_read_return

/* run_sim.sh */
#!/bin/sh
# build the DRAM chip testbench with Verilator and run it
# result is taken from the log, a nonzero run status also counts as failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Test failures found"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module dram_chip_tb -o sim_dram_chip
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_dram_chip > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation finished without errors"
exit 0

/* testbench/dram_chip_tb.sv */
// ##############################
// testbench for the single rate DRAM chip model
// drives bus commands, predicts read bursts with a shadow array
// ##############################
`timescale 1ns/1ps

module dram_chip_tb import dram_pkg::*; ();

    localparam int RAND_ROUNDS    = 60;                  // masked write plus read, random
    localparam int ROUND_CYCLES   = 20;                  // upper bound for one round
    localparam int DIRECTED_CYCLES = 300;                // reset and directed tests
    localparam int TIMEOUT_CYCLES = 2 * (RAND_ROUNDS * ROUND_CYCLES + DIRECTED_CYCLES);

    logic                  clk_in;
    logic                  rst_N_in;
    logic                  cs_n;
    logic                  act_n;
    logic [ADDR_BITS-1:0]  addr;
    logic [1:0]            bg;
    logic [1:0]            ba;
    logic [DATA_WIDTH-1:0] dq_wr;
    logic [DATA_WIDTH-1:0] dm;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rd_drive;

    integer                seed = 32'h2454;
    int                    cyc = 0;                      // edge number, bumped at each rising edge
    logic                  checking = 1'b0;

    // shadow of every cell plus the open row per bank
    logic [DATA_WIDTH-1:0] model_mem [NUM_BANKS][ROWS][COLS];
    int                    model_row [NUM_BANKS];

    // scheduled read beats, edge number and data
    int                    exp_edge[$];
    logic [DATA_WIDTH-1:0] exp_data[$];

    dram_chip_top dut_i (
        .clk_in   (clk_in),
        .rst_N_in (rst_N_in),
        .cs_n     (cs_n),
        .act_n    (act_n),
        .addr     (addr),
        .bg       (bg),
        .ba       (ba),
        .dq_wr    (dq_wr),
        .dm       (dm),
        .rd_data  (rd_data),
        .rd_drive (rd_drive)
    );

    always #10 clk_in = ~clk_in;                         // 20 ns period

    always @(posedge clk_in) cyc <= cyc + 1;

    always @(posedge clk_in) begin
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cyc);
            $display("Test failures found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // beat k of a burst comes from the aligned group, starting at col and wrapping
    function automatic int wrap_column(input int col, input int k);
        return (col / BURST_LEN) * BURST_LEN + (col + k) % BURST_LEN;
    endfunction

    // reference model, expected read beat k for a burst at col
    function automatic logic [DATA_WIDTH-1:0] expected_beat(input int bank, input int col,
                                                           input int k);
        return model_mem[bank][model_row[bank]][wrap_column(col, k)];
    endfunction

    task automatic report_mismatch(input string what);
        $display("Mismatch at %0t ns: %s", $time, what);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    // outputs are read 1 ns after the edge that registered them
    always @(posedge clk_in) begin
        #1;
        if (checking) begin
            if (exp_edge.size() != 0 && exp_edge[0] == cyc) begin
                assert (rd_drive === 1'b1)
                    else report_mismatch($sformatf("rd_drive low at edge %0d of a burst", cyc));
                assert (rd_data === exp_data[0])
                    else report_mismatch($sformatf("rd_data %h, expected %h at edge %0d",
                                                   rd_data, exp_data[0], cyc));
                exp_edge.delete(0);
                exp_data.delete(0);
            end else begin
                assert (rd_drive === 1'b0)
                    else report_mismatch($sformatf("rd_drive high at edge %0d, no beat due", cyc));
            end
        end
    end

    // next edge plus 2 ns, bus back to deselected
    task automatic step();
        @(posedge clk_in);
        #2;
        cs_n  = 1'b1;
        act_n = 1'b1;
        addr  = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic select_bank(input int bank);
        logic [BANK_BITS-1:0] b;
        b  = BANK_BITS'(bank);
        bg = {1'b0, b[2]};                               // bg[1] is don't care on x16
        ba = b[1:0];
    endtask

    task automatic drive_cmd(input logic [2:0] pattern, input int bank, input int low);
        cs_n  = 1'b0;
        act_n = 1'b1;
        addr  = {pattern, (ADDR_BITS-3)'(low)};
        select_bank(bank);
    endtask

    task automatic activate_row(input int bank, input int row);
        step();
        cs_n  = 1'b0;
        act_n = 1'b0;
        addr  = ADDR_BITS'(row);
        select_bank(bank);
        model_row[bank] = row;
        idle_cycles(ACT_LATENCY - 1);                    // next command lands at t+ACT
    endtask

    task automatic precharge_bank(input int bank);
        step();
        drive_cmd(CMD_PRE, bank, 0);
        idle_cycles(PRE_LATENCY - 1);
    endtask

    task automatic write_burst(input int bank, input int col, input bit use_mask);
        logic [DATA_WIDTH-1:0] data [BURST_LEN];
        logic [DATA_WIDTH-1:0] mask [BURST_LEN];
        int                    c;
        for (int k = 0; k < BURST_LEN; k++) begin
            data[k] = DATA_WIDTH'($random(seed));
            mask[k] = use_mask ? DATA_WIDTH'($random(seed)) : '0;
        end
        step();
        drive_cmd(CMD_WRITE, bank, col);
        dq_wr = data[0];                                 // beat 0 rides with the command
        dm    = mask[0];
        for (int k = 1; k < BURST_LEN; k++) begin
            step();
            dq_wr = data[k];
            dm    = mask[k];
        end
        for (int k = 0; k < BURST_LEN; k++) begin
            c = wrap_column(col, k);
            model_mem[bank][model_row[bank]][c] =
                (model_mem[bank][model_row[bank]][c] & mask[k]) | (data[k] & ~mask[k]);
        end
        idle_cycles(2);                                  // data readable from t+BURST_LEN+2
    endtask

    task automatic read_burst(input int bank, input int col);
        int t;
        step();
        drive_cmd(CMD_READ, bank, col);
        t = cyc + 1;                                     // edge that samples the read
        for (int k = 0; k < BURST_LEN; k++) begin
            exp_edge.push_back(t + CAS_LATENCY + k);
            exp_data.push_back(expected_beat(bank, col, k));
        end
    endtask

    task automatic drain_reads();
        step();
        while (exp_edge.size() != 0) step();
    endtask

    // every command type with cs_n high, none may reach a bank
    task automatic deselected_traffic(input int bank, input int col);
        step();
        act_n = 1'b0;
        addr  = ADDR_BITS'(col);
        select_bank(bank);
        step();
        drive_cmd(CMD_WRITE, bank, col);
        cs_n = 1'b1;
        for (int k = 0; k < BURST_LEN; k++) begin
            if (k != 0) step();
            dq_wr = DATA_WIDTH'($random(seed));
            dm    = '0;
        end
        step();
        drive_cmd(CMD_PRE, bank, 0);
        cs_n = 1'b1;
        step();
        drive_cmd(CMD_READ, bank, col);
        cs_n = 1'b1;
        idle_cycles(2);
    endtask

    initial begin
        logic [31:0] pick;
        int          bank;
        int          base;
        clk_in   = 1'b0;
        rst_N_in = 1'b1;
        cs_n     = 1'b1;
        act_n    = 1'b1;
        addr     = '0;
        bg       = '0;
        ba       = '0;
        dq_wr    = '0;
        dm       = '0;
        repeat (2) @(posedge clk_in);
        #2;
        rst_N_in = 1'b0;
        checking = 1'b1;

        // quiet port while rows open, writes land and deselected traffic runs
        activate_row(0, 3);
        deselected_traffic(0, 4);
        write_burst(0, 5, 1'b0);                         // columns 5 6 7 4
        idle_cycles(10);

        // unmasked data back in wrap order
        read_burst(0, 6);
        drain_reads();

        // masked rewrite of the same group
        write_burst(0, 5, 1'b1);
        read_burst(0, 4);
        drain_reads();

        // another row in between, then the first row again
        precharge_bank(0);
        activate_row(0, 9);
        write_burst(0, 5, 1'b0);
        precharge_bank(0);
        activate_row(0, 3);
        read_burst(0, 7);
        drain_reads();

        // two banks, reads BURST_LEN apart come back back to back
        activate_row(5, 12);
        write_burst(5, 10, 1'b0);
        read_burst(0, 4);
        idle_cycles(BURST_LEN - 1);
        read_burst(5, 9);
        drain_reads();

        // deselected commands leave both banks as they were
        deselected_traffic(0, 5);
        deselected_traffic(5, 8);
        read_burst(0, 5);
        idle_cycles(BURST_LEN - 1);
        read_burst(5, 8);
        drain_reads();

        // random masked writes and reads in the two written groups
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            pick = $random(seed);
            bank = pick[0] ? 5 : 0;
            base = pick[0] ? 8 : 4;
            write_burst(bank, base + int'(pick[2:1]), 1'b1);
            read_burst(bank, base + int'(pick[4:3]));
            drain_reads();
        end

        $display("All tests passed!");
        $finish;
    end

endmodule : dram_chip_tb
